//--- trap_params.svh
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Data path width
`define TRAP_XLEN       32

// First instruction fetched after reset, also the default EPC
`define TRAP_RESET_PC   32'h0001_0000

// Machine trap CSR addresses
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343

// Trap vector base after reset
`define MTVEC_RESET     32'h0001_0100

`endif

//--- trap_pkg.sv
package trap_pkg;

    // Internal exception cause, ordered as the prioritizer encodes it
    typedef enum logic [1:0]
    {
        EXC_NONE            = 2'b00,
        EXC_I_ADDR_MISALIGN = 2'b01,
        EXC_ILLEGAL_IR      = 2'b10,
        EXC_ECALL           = 2'b11
    } exc_cause_e;

    // Software CSR access command, valid for one cycle
    typedef enum logic [1:0]
    {
        CSR_NOP   = 2'b00,
        CSR_READ  = 2'b01,
        CSR_WRITE = 2'b10
    } csr_op_e;

endpackage

//--- trap_if.sv
`include "trap_params.svh"

interface trap_if
    import trap_pkg::*;
();

    // Selected exception for the current cycle
    logic                  raised;
    exc_cause_e            cause;
    logic [`TRAP_XLEN-1:0] epc;
    logic [`TRAP_XLEN-1:0] tval;

    modport producer
    (
        output raised,
        output cause,
        output epc,
        output tval
    );

    modport consumer
    (
        input raised,
        input cause,
        input epc,
        input tval
    );

endinterface

//--- exception_ctrl.sv
`include "trap_params.svh"

module exception_ctrl
    import trap_pkg::*;
(
    // PC of the instruction now in flight
    input  logic [`TRAP_XLEN-1:0] current_pc,

    // Fetch address misaligned
    input  logic                  i_addr_misaligned,
    input  logic [`TRAP_XLEN-1:0] pc_of_i_addr_misaligned,

    // Illegal instruction, PC taken from the ID stage
    input  logic                  illegal_ir,
    input  logic [`TRAP_XLEN-1:0] ir_in_question,
    input  logic [`TRAP_XLEN-1:0] pc_of_illegal_ir,

    input  logic                  is_ecall,

    // Instruction is being flushed by a jump
    input  logic                  jump,

    trap_if.producer              exc
);

    logic       suppress;
    exc_cause_e cause;

    // Nothing traps on the very first instruction or on a flushed one
    assign suppress = (current_pc == `TRAP_RESET_PC) || jump;

    // Illegal instruction beats misaligned fetch beats ECALL
    always_comb
    begin
        if (suppress)
            cause = EXC_NONE;
        else if (illegal_ir)
            cause = EXC_ILLEGAL_IR;
        else if (i_addr_misaligned)
            cause = EXC_I_ADDR_MISALIGN;
        else if (is_ecall)
            cause = EXC_ECALL;
        else
            cause = EXC_NONE;
    end

    // EPC and trap value follow the winning cause
    always_comb
    begin
        case (cause)
            EXC_ILLEGAL_IR:
            begin
                exc.epc  = pc_of_illegal_ir;
                exc.tval = ir_in_question;
            end
            EXC_I_ADDR_MISALIGN:
            begin
                exc.epc  = pc_of_i_addr_misaligned;
                exc.tval = pc_of_i_addr_misaligned;
            end
            EXC_ECALL:
            begin
                // ECALL is decoded in ID, so it shares that PC
                exc.epc  = pc_of_illegal_ir;
                exc.tval = '0;
            end
            default:
            begin
                exc.epc  = `TRAP_RESET_PC;
                exc.tval = '0;
            end
        endcase
    end

    assign exc.cause  = cause;
    assign exc.raised = (cause != EXC_NONE);

endmodule

//--- trap_csr.sv
`include "trap_params.svh"

module trap_csr
    import trap_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    trap_if.consumer              exc,

    // Software access port
    input  csr_op_e               csr_op,
    input  logic [11:0]           csr_addr,
    input  logic [`TRAP_XLEN-1:0] csr_wdata,
    output logic [`TRAP_XLEN-1:0] csr_rdata,

    // Live values for the redirect logic
    output logic [`TRAP_XLEN-1:0] mtvec,
    output logic [`TRAP_XLEN-1:0] mepc
);

    logic [`TRAP_XLEN-1:0] mtvec_q;
    logic [`TRAP_XLEN-1:0] mepc_q;
    logic [`TRAP_XLEN-1:0] mcause_q;
    logic [`TRAP_XLEN-1:0] mtval_q;
    logic                  wr_en;

    // Architectural exception codes from the privileged spec
    function automatic logic [`TRAP_XLEN-1:0] arch_code(input exc_cause_e cause);
        logic [`TRAP_XLEN-1:0] code;
        begin
            case (cause)
                EXC_I_ADDR_MISALIGN: code = `TRAP_XLEN'd0;
                EXC_ILLEGAL_IR:      code = `TRAP_XLEN'd2;
                EXC_ECALL:           code = `TRAP_XLEN'd11;
                default:             code = `TRAP_XLEN'd0;
            endcase
            return code;
        end
    endfunction

    assign wr_en = (csr_op == CSR_WRITE);

    // mtvec only changes by software
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mtvec_q <= `MTVEC_RESET;
        else if (wr_en && csr_addr == `CSR_MTVEC)
            // Direct mode only, base kept word aligned
            mtvec_q <= {csr_wdata[`TRAP_XLEN-1:2], 2'b00};
    end

    // Exception capture overrides a software write in the same cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (exc.raised)
        begin
            mepc_q   <= exc.epc;
            mcause_q <= arch_code(exc.cause);
            mtval_q  <= exc.tval;
        end
        else if (wr_en)
        begin
            case (csr_addr)
                `CSR_MEPC:   mepc_q   <= csr_wdata;
                `CSR_MCAUSE: mcause_q <= csr_wdata;
                `CSR_MTVAL:  mtval_q  <= csr_wdata;
                default:     ;
            endcase
        end
    end

    // Read data only while a read is requested, unmapped reads as zero
    always_comb
    begin
        csr_rdata = '0;
        if (csr_op == CSR_READ)
        begin
            case (csr_addr)
                `CSR_MTVEC:  csr_rdata = mtvec_q;
                `CSR_MEPC:   csr_rdata = mepc_q;
                `CSR_MCAUSE: csr_rdata = mcause_q;
                `CSR_MTVAL:  csr_rdata = mtval_q;
                default:     csr_rdata = '0;
            endcase
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

//--- trap_redirect.sv
`include "trap_params.svh"

module trap_redirect
(
    input  logic                  clk,
    input  logic                  arst_n,

    trap_if.consumer              exc,

    // Return from trap, one-cycle strobe
    input  logic                  mret,

    input  logic [`TRAP_XLEN-1:0] mtvec,
    input  logic [`TRAP_XLEN-1:0] mepc,

    // Fetch redirect, one-cycle pulse per event
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    logic                  event_hit;
    logic [`TRAP_XLEN-1:0] target_pc;

    assign event_hit = exc.raised || mret;

    // Trap entry wins over a return in the same cycle
    assign target_pc = exc.raised ? mtvec : mepc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            redirect_valid <= 1'b0;
        else
            redirect_valid <= event_hit;
    end

    // Target only loads on an event
    always_ff @(posedge clk)
    begin
        if (event_hit)
            redirect_pc <= target_pc;
    end

endmodule

//--- trap_unit.sv
`include "trap_params.svh"

module trap_unit
    import trap_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Pipeline status for the current cycle
    input  logic [`TRAP_XLEN-1:0] current_pc,
    input  logic                  i_addr_misaligned,
    input  logic [`TRAP_XLEN-1:0] pc_of_i_addr_misaligned,
    input  logic                  illegal_ir,
    input  logic [`TRAP_XLEN-1:0] ir_in_question,
    input  logic [`TRAP_XLEN-1:0] pc_of_illegal_ir,
    input  logic                  is_ecall,
    input  logic                  jump,
    input  logic                  mret,

    // CSR command
    input  csr_op_e               csr_op,
    input  logic [11:0]           csr_addr,
    input  logic [`TRAP_XLEN-1:0] csr_wdata,

    output logic                  exception_raised,
    output exc_cause_e            exception_cause,
    output logic [`TRAP_XLEN-1:0] exception_epc,
    output logic [`TRAP_XLEN-1:0] exception_tval,
    output logic [`TRAP_XLEN-1:0] csr_rdata,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    logic [`TRAP_XLEN-1:0] mtvec;
    logic [`TRAP_XLEN-1:0] mepc;

    trap_if u_exc_if ();

    exception_ctrl u_exception_ctrl
    (
        .current_pc              (current_pc),
        .i_addr_misaligned       (i_addr_misaligned),
        .pc_of_i_addr_misaligned (pc_of_i_addr_misaligned),
        .illegal_ir              (illegal_ir),
        .ir_in_question          (ir_in_question),
        .pc_of_illegal_ir        (pc_of_illegal_ir),
        .is_ecall                (is_ecall),
        .jump                    (jump),
        .exc                     (u_exc_if.producer)
    );

    trap_csr u_trap_csr
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .exc       (u_exc_if.consumer),
        .csr_op    (csr_op),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    trap_redirect u_trap_redirect
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .exc            (u_exc_if.consumer),
        .mret           (mret),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // Selected exception visible to the core
    assign exception_raised = u_exc_if.raised;
    assign exception_cause  = u_exc_if.cause;
    assign exception_epc    = u_exc_if.epc;
    assign exception_tval   = u_exc_if.tval;

endmodule

//--- trap_unit_sva.sv
module trap_unit_sva
    import trap_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       mret,
    input logic       exception_raised,
    input exc_cause_e exception_cause,
    input logic       redirect_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Each pulse owns the event of the cycle before it
    a_pulse_per_event: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> $past(exception_raised || mret))
    else
        $error("redirect pulse without a trap or return one cycle earlier");

    a_raised_matches_cause: assert property (@(posedge clk) disable iff (!arst_n)
        exception_raised == (exception_cause != EXC_NONE))
    else
        $error("exception_raised disagrees with exception_cause");

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !redirect_valid)
    else
        $error("redirect_valid high while reset is asserted");

endmodule

bind trap_unit trap_unit_sva u_trap_unit_sva
(
    .clk              (clk),
    .arst_n           (arst_n),
    .mret             (mret),
    .exception_raised (exception_raised),
    .exception_cause  (exception_cause),
    .redirect_valid   (redirect_valid)
);

//--- trap_unit_tb.sv
`include "trap_params.svh"

module trap_unit_tb
    import trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          RAND_CYCLES    = 200;
    localparam int          TIMEOUT_CYCLES = 5 * (RAND_CYCLES + 200);
    localparam logic [31:0] PC_MID         = 32'h0001_0040;

    typedef struct packed
    {
        exc_cause_e  cause;
        logic [31:0] epc;
        logic [31:0] tval;
    } exc_ref_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [`TRAP_XLEN-1:0] current_pc;
    logic                  i_addr_misaligned;
    logic [`TRAP_XLEN-1:0] pc_of_i_addr_misaligned;
    logic                  illegal_ir;
    logic [`TRAP_XLEN-1:0] ir_in_question;
    logic [`TRAP_XLEN-1:0] pc_of_illegal_ir;
    logic                  is_ecall;
    logic                  jump;
    logic                  mret;
    csr_op_e               csr_op;
    logic [11:0]           csr_addr;
    logic [`TRAP_XLEN-1:0] csr_wdata;
    logic                  exception_raised;
    exc_cause_e            exception_cause;
    logic [`TRAP_XLEN-1:0] exception_epc;
    logic [`TRAP_XLEN-1:0] exception_tval;
    logic [`TRAP_XLEN-1:0] csr_rdata;
    logic                  redirect_valid;
    logic [`TRAP_XLEN-1:0] redirect_pc;

    // Shadow CSRs and the redirect expected after the next edge
    logic [31:0] sh_mtvec  = `MTVEC_RESET;
    logic [31:0] sh_mepc   = '0;
    logic [31:0] sh_mcause = '0;
    logic [31:0] sh_mtval  = '0;
    logic        exp_rv    = 1'b0;
    logic [31:0] exp_rpc   = '0;

    logic [31:0] lfsr_q      = 32'h7245_c176;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    string       test_name   = "reset";

    trap_unit dut_i (.*);

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            bits = {bits[30:0], lfsr_q[0]};
        end
    endtask

    function automatic exc_ref_t ref_exception(
        input logic [31:0] pc, input logic mis, input logic [31:0] mis_pc, input logic ill,
        input logic [31:0] ir, input logic [31:0] id_pc, input logic ecall, input logic jmp);
        exc_ref_t r;
        r.cause = EXC_NONE;
        r.epc   = `TRAP_RESET_PC;
        r.tval  = '0;
        if (pc != `TRAP_RESET_PC && !jmp)
        begin
            if (ill)
                r = '{EXC_ILLEGAL_IR, id_pc, ir};
            else if (mis)
                r = '{EXC_I_ADDR_MISALIGN, mis_pc, mis_pc};
            else if (ecall)
                r = '{EXC_ECALL, id_pc, 32'd0};
        end
        return r;
    endfunction

    function automatic logic [31:0] mcause_code(input exc_cause_e cause);
        case (cause)
            EXC_ILLEGAL_IR: return 32'd2;
            EXC_ECALL:      return 32'd11;
            default:        return 32'd0;
        endcase
    endfunction

    function automatic logic [11:0] csr_addr_of(input logic [1:0] sel);
        case (sel)
            2'd0:    return `CSR_MTVEC;
            2'd1:    return `CSR_MEPC;
            2'd2:    return `CSR_MCAUSE;
            default: return `CSR_MTVAL;
        endcase
    endfunction

    function automatic logic [31:0] shadow_read(input logic [11:0] addr);
        case (addr)
            `CSR_MTVEC:  return sh_mtvec;
            `CSR_MEPC:   return sh_mepc;
            `CSR_MCAUSE: return sh_mcause;
            `CSR_MTVAL:  return sh_mtval;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp)
        else
        begin
            error_count++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic idle_inputs();
        current_pc              <= PC_MID;
        i_addr_misaligned       <= 1'b0;
        pc_of_i_addr_misaligned <= '0;
        illegal_ir              <= 1'b0;
        ir_in_question          <= '0;
        pc_of_illegal_ir        <= '0;
        is_ecall                <= 1'b0;
        jump                    <= 1'b0;
        mret                    <= 1'b0;
        csr_op                  <= CSR_NOP;
        csr_addr                <= '0;
        csr_wdata               <= '0;
    endtask

    // One cycle of pipeline flags with fresh PCs and instruction word
    task automatic flag_cycle(input logic [31:0] pc, input logic mis, input logic ill,
                              input logic ecall, input logic jmp, input logic ret);
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] word;
        take_bits(32, pc_a);
        take_bits(32, pc_b);
        take_bits(32, word);
        @(posedge clk);
        idle_inputs();
        current_pc              <= pc;
        i_addr_misaligned       <= mis;
        pc_of_i_addr_misaligned <= {pc_a[31:2], 2'b10};
        illegal_ir              <= ill;
        ir_in_question          <= word;
        pc_of_illegal_ir        <= {pc_b[31:2], 2'b00};
        is_ecall                <= ecall;
        jump                    <= jmp;
        mret                    <= ret;
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] pc;
        take_bits(12, r);
        take_bits(32, pc);
        // Reset PC on one cycle in eight, jump on one in four
        flag_cycle((r[8:6] == 3'd0) ? `TRAP_RESET_PC : pc, r[0], r[1], r[2], r[3] & r[4], r[5]);
        csr_op   <= r[9] ? CSR_READ : CSR_NOP;
        csr_addr <= csr_addr_of(r[11:10]);
    endtask

    // Four trap CSRs, then one unmapped address
    task automatic read_all();
        for (int i = 0; i < 5; i++)
        begin
            @(posedge clk);
            idle_inputs();
            csr_op   <= CSR_READ;
            csr_addr <= (i < 4) ? csr_addr_of(i[1:0]) : 12'h7c0;
        end
    endtask

    // Outputs are compared mid-cycle, then the shadow steps past the next edge
    always @(negedge clk)
    begin : compare_outputs
        exc_ref_t want;
        want = ref_exception(current_pc, i_addr_misaligned, pc_of_i_addr_misaligned,
                             illegal_ir, ir_in_question, pc_of_illegal_ir, is_ecall, jump);
        check_value("cause", 32'(want.cause), 32'(exception_cause));
        check_value("raised", 32'(want.cause != EXC_NONE), 32'(exception_raised));
        check_value("epc", want.epc, exception_epc);
        check_value("tval", want.tval, exception_tval);
        check_value("redirect_valid", 32'(exp_rv), 32'(redirect_valid));
        if (exp_rv)
            check_value("redirect_pc", exp_rpc, redirect_pc);
        check_value("csr_rdata", (csr_op == CSR_READ) ? shadow_read(csr_addr) : 32'd0, csr_rdata);
        if (!arst_n)
        begin
            sh_mtvec  = `MTVEC_RESET;
            sh_mepc   = '0;
            sh_mcause = '0;
            sh_mtval  = '0;
            exp_rv    = 1'b0;
        end
        else
        begin
            exp_rv = (want.cause != EXC_NONE) || mret;
            if (want.cause != EXC_NONE)
                exp_rpc = sh_mtvec;
            else if (mret)
                exp_rpc = sh_mepc;
            if (csr_op == CSR_WRITE && csr_addr == `CSR_MTVEC)
                sh_mtvec = {csr_wdata[31:2], 2'b00};
            if (want.cause != EXC_NONE)
            begin
                sh_mepc   = want.epc;
                sh_mcause = mcause_code(want.cause);
                sh_mtval  = want.tval;
            end
            else if (csr_op == CSR_WRITE && csr_addr == `CSR_MEPC)
                sh_mepc = csr_wdata;
            else if (csr_op == CSR_WRITE && csr_addr == `CSR_MCAUSE)
                sh_mcause = csr_wdata;
            else if (csr_op == CSR_WRITE && csr_addr == `CSR_MTVAL)
                sh_mtval = csr_wdata;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        arst_n <= 1'b0;
        idle_inputs();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        test_name = "reset_values";
        read_all();

        test_name = "priority_random";
        repeat (RAND_CYCLES) random_cycle();

        test_name = "all_flags";
        flag_cycle(PC_MID, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        read_all();
        flag_cycle(PC_MID, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        flag_cycle(`TRAP_RESET_PC, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);

        test_name = "back_to_back";
        flag_cycle(PC_MID, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        flag_cycle(PC_MID, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        flag_cycle(PC_MID, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        read_all();

        test_name = "mret";
        flag_cycle(PC_MID, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        flag_cycle(PC_MID, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
        read_all();

        test_name = "mtvec_write";
        @(posedge clk);
        idle_inputs();
        csr_op    <= CSR_WRITE;
        csr_addr  <= `CSR_MTVEC;
        csr_wdata <= 32'h0002_0203;
        read_all();
        flag_cycle(PC_MID, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        // Capture must override the software write
        test_name = "mepc_override";
        flag_cycle(PC_MID, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        csr_op    <= CSR_WRITE;
        csr_addr  <= `CSR_MEPC;
        csr_wdata <= 32'hdead_beef;
        read_all();

        @(posedge clk);
        idle_inputs();
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- trap_unit.f
+incdir+.
trap_pkg.sv
trap_if.sv
exception_ctrl.sv
trap_csr.sv
trap_redirect.sv
trap_unit.sv
trap_unit_sva.sv
trap_unit_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f trap_unit.f --top-module trap_unit_tb -o trap_unit_sim
	./obj_dir/trap_unit_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "TB PASSED" $(LOG) && ! grep -q "TB FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
